// ==== source/line_pkg.sv ====
// ======================================================================
// line package
// coordinate, command and colour types shared by the line subsystem
// ======================================================================

`default_nettype none

package line_pkg;

    localparam int CORDW = 16;  // signed coordinate width
    localparam int CIDXW = 4;   // colour index width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0] cidx_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef enum logic {
        op_clear = 1'b0,  // fill whole framebuffer
        op_line  = 1'b1   // bresenham line
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t op;
        coord_t  x0;
        coord_t  y0;
        coord_t  x1;
        coord_t  y1;
        cidx_t   cidx;
    } line_cmd_t;

    // one framebuffer write
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } fb_wr_t;

    // 16 colour palette, 0 is black and 15 is white
    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h125, 12'h725, 12'h085,
        12'ha53, 12'h554, 12'hccc, 12'hf04,
        12'hfa0, 12'hfe2, 12'h0e3, 12'h2af,
        12'h879, 12'hf7a, 12'hfca, 12'hfff
    };

endpackage

`default_nettype wire

// ==== source/display_timing.sv ====
// ======================================================================
// display timing
// pixel and line counters with sync, data enable and frame strobes
// ======================================================================

`default_nettype none
`timescale 1ns/10ps

module display_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire logic       clk_pix,
    input  wire logic       rst,
    output line_pkg::coord_t sx,
    output line_pkg::coord_t sy,
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output logic            frame,
    output logic            line
);

    // all limits as coordinates so compares stay one width
    localparam line_pkg::coord_t H_ACT  = line_pkg::coord_t'(H_ACTIVE);
    localparam line_pkg::coord_t HS_BEG = line_pkg::coord_t'(H_ACTIVE + H_FRONT);
    localparam line_pkg::coord_t HS_END = line_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam line_pkg::coord_t H_LAST =
        line_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam line_pkg::coord_t V_ACT  = line_pkg::coord_t'(V_ACTIVE);
    localparam line_pkg::coord_t VS_BEG = line_pkg::coord_t'(V_ACTIVE + V_FRONT);
    localparam line_pkg::coord_t VS_END = line_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam line_pkg::coord_t V_LAST =
        line_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    line_pkg::coord_t sx_next, sy_next;  // position for the coming cycle

    always_comb begin
        sx_next = sx + 1'b1;
        sy_next = sy;
        if (sx == H_LAST) begin  // wrap line
            sx_next = '0;
            sy_next = (sy == V_LAST) ? '0 : sy + 1'b1;
        end
    end

    // decode from next position so flags line up with sx and sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= H_LAST;  // park on last pixel, first active pixel follows
            sy    <= V_LAST;
            hsync <= 1'b1;    // active low
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= ~(sx_next >= HS_BEG && sx_next < HS_END);
            vsync <= ~(sy_next >= VS_BEG && sy_next < VS_END);
            de    <= (sx_next < H_ACT) && (sy_next < V_ACT);
            frame <= (sx_next == 0) && (sy_next == V_ACT);  // start of vblank
            line  <= (sx_next == 0);
        end
    end

endmodule

`default_nettype wire

// ==== source/draw_line.sv ====
// ======================================================================
// draw line
// bresenham engine, one coordinate per cycle in any octant
// ======================================================================

`default_nettype none
`timescale 1ns/10ps

module draw_line (
    input  wire logic             clk_pix,
    input  wire logic             rst,
    input  wire logic             start,  // one cycle, ignored while drawing
    input  wire line_pkg::coord_t x0,
    input  wire line_pkg::coord_t y0,
    input  wire line_pkg::coord_t x1,
    input  wire line_pkg::coord_t y1,
    output line_pkg::coord_t      x,
    output line_pkg::coord_t      y,
    output logic                  drawing,
    output logic                  done
);

    localparam int EW = line_pkg::CORDW + 3;  // error term headroom

    line_pkg::coord_t xa, ya, xb, yb;     // end points, top one first
    line_pkg::coord_t x_end, y_end;
    logic signed [EW-1:0] dx_s, dy_s;     // deltas from the ports
    logic signed [EW-1:0] dx, dy, err, e2;
    logic right, right_s;                 // x direction

    enum logic {st_idle, st_draw} state;

    // order end points so y only ever counts up
    always_comb begin
        if (y0 > y1) begin
            xa = x1;
            ya = y1;
            xb = x0;
            yb = y0;
        end else begin
            xa = x0;
            ya = y0;
            xb = x1;
            yb = y1;
        end
        right_s = (xa < xb);
        dx_s = right_s ? EW'(xb) - EW'(xa) : EW'(xa) - EW'(xb);  // always >= 0
        dy_s = EW'(ya) - EW'(yb);  // always <= 0
        e2 = err <<< 1;
    end

    always_comb drawing = (state == st_draw);
    always_comb done = drawing && (x == x_end) && (y == y_end);  // with last point

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (start) state <= st_draw;
                st_draw: if (done) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // coordinate and error datapath
    always_ff @(posedge clk_pix) begin
        if (state == st_idle) begin
            x     <= xa;  // first point shows the cycle after start
            y     <= ya;
            x_end <= xb;
            y_end <= yb;
            right <= right_s;
            dx    <= dx_s;
            dy    <= dy_s;
            err   <= dx_s + dy_s;
        end else if (!done) begin
            if (e2 >= dy && e2 <= dx) begin  // diagonal step
                x   <= right ? x + 1'b1 : x - 1'b1;
                y   <= y + 1'b1;
                err <= err + dx + dy;
            end else if (e2 >= dy) begin     // x only
                x   <= right ? x + 1'b1 : x - 1'b1;
                err <= err + dy;
            end else if (e2 <= dx) begin     // y only
                y   <= y + 1'b1;
                err <= err + dx;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/draw_sequencer.sv ====
// ======================================================================
// draw sequencer
// takes commands and turns them into framebuffer writes after vblank
// ======================================================================

`default_nettype none
`timescale 1ns/10ps

module draw_sequencer #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  wire logic                clk_pix,
    input  wire logic                rst,
    input  wire logic                cmd_valid,
    input  wire logic                frame,
    input  wire line_pkg::line_cmd_t cmd,
    output logic                     cmd_busy,
    output logic                     fb_we,
    output line_pkg::fb_wr_t         fb_wr
);

    localparam line_pkg::coord_t X_LIM  = line_pkg::coord_t'(FB_WIDTH);
    localparam line_pkg::coord_t Y_LIM  = line_pkg::coord_t'(FB_HEIGHT);
    localparam line_pkg::coord_t X_LAST = line_pkg::coord_t'(FB_WIDTH - 1);
    localparam line_pkg::coord_t Y_LAST = line_pkg::coord_t'(FB_HEIGHT - 1);

    enum logic [2:0] {st_idle, st_wait, st_clear, st_line, st_done} state;

    line_pkg::line_cmd_t cmd_r;   // held for the whole command
    line_pkg::coord_t    cx, cy;  // clear sweep position
    line_pkg::coord_t    lx, ly;  // line engine output
    logic line_start, line_drawing, line_done;
    logic in_bounds;

    draw_line u_draw_line (
        .clk_pix,
        .rst,
        .start   (line_start),
        .x0      (cmd_r.x0),
        .y0      (cmd_r.y0),
        .x1      (cmd_r.x1),
        .y1      (cmd_r.y1),
        .x       (lx),
        .y       (ly),
        .drawing (line_drawing),
        .done    (line_done)
    );

    // clip anything off the framebuffer so nothing wraps rows
    always_comb in_bounds = (lx >= 0) && (lx < X_LIM) && (ly >= 0) && (ly < Y_LIM);
    always_comb cmd_busy = (state != st_idle);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state      <= st_idle;
            line_start <= 1'b0;
            fb_we      <= 1'b0;
        end else begin
            line_start <= 1'b0;
            fb_we      <= 1'b0;
            case (state)
                st_idle: if (cmd_valid) state <= st_wait;
                st_wait: begin
                    if (frame) begin  // only draw in blanking
                        state      <= (cmd_r.op == line_pkg::op_clear) ? st_clear : st_line;
                        line_start <= (cmd_r.op == line_pkg::op_line);
                    end
                end
                st_clear: begin
                    fb_we <= 1'b1;
                    if (cx == X_LAST && cy == Y_LAST) state <= st_done;
                end
                st_line: begin
                    fb_we <= line_drawing && in_bounds;
                    if (line_done) state <= st_done;  // last point goes out next
                end
                st_done: state <= st_idle;  // last write on the bus now
                default: state <= st_idle;
            endcase
        end
    end

    // command hold, sweep counters, write payload
    always_ff @(posedge clk_pix) begin
        if (state == st_idle && cmd_valid) cmd_r <= cmd;
        if (state == st_wait) begin
            cx <= '0;
            cy <= '0;
        end
        if (state == st_clear) begin
            fb_wr <= '{x: cx, y: cy, cidx: cmd_r.cidx};
            if (cx == X_LAST) begin  // next row
                cx <= '0;
                cy <= cy + 1'b1;
            end else begin
                cx <= cx + 1'b1;
            end
        end else begin
            fb_wr <= '{x: lx, y: ly, cidx: cmd_r.cidx};
        end
    end

endmodule

`default_nettype wire

// ==== source/framebuffer.sv ====
// ======================================================================
// framebuffer
// colour index memory, scaled scan out and palette lookup
// ======================================================================

`default_nettype none
`timescale 1ns/10ps

module framebuffer #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240,
    parameter int SCALE     = 2
) (
    input  wire logic             clk_pix,
    input  wire logic             fb_we,
    input  wire logic             de,
    input  wire line_pkg::fb_wr_t fb_wr,
    input  wire line_pkg::coord_t sx,
    input  wire line_pkg::coord_t sy,
    output line_pkg::rgb_t        rgb
);

    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int AW = $clog2(DEPTH);
    localparam int SW = (SCALE > 1) ? $clog2(SCALE) : 1;
    localparam logic [SW-1:0] SUB_LAST = SW'(SCALE - 1);
    localparam logic [AW-1:0] ROW_STEP = AW'(FB_WIDTH);

    line_pkg::cidx_t mem [DEPTH];
    line_pkg::cidx_t cidx_q;       // read data
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] col_addr, row_base;  // next read, start of current fb row
    logic [AW-1:0] cur_col, cur_row;
    logic [SW-1:0] sub_x, sub_y;        // repeats within one fb pixel
    logic [SW-1:0] cur_subx, cur_suby;
    logic frame_start, de_q;

    always_comb wr_addr = AW'($unsigned(fb_wr.y)) * ROW_STEP + AW'($unsigned(fb_wr.x));

    always_ff @(posedge clk_pix) begin
        if (fb_we) mem[wr_addr] <= fb_wr.cidx;
    end

    // first active pixel restarts the scan
    always_comb begin
        frame_start = (sx == 0) && (sy == 0);
        cur_col  = frame_start ? '0 : col_addr;
        cur_row  = frame_start ? '0 : row_base;
        cur_subx = frame_start ? '0 : sub_x;
        cur_suby = frame_start ? '0 : sub_y;
    end

    always_ff @(posedge clk_pix) begin
        de_q <= de;
        if (de) begin
            cidx_q   <= mem[cur_col];
            row_base <= cur_row;
            sub_y    <= cur_suby;
            if (cur_subx == SUB_LAST) begin  // move to next fb column
                sub_x    <= '0;
                col_addr <= cur_col + 1'b1;
            end else begin
                sub_x    <= cur_subx + 1'b1;
                col_addr <= cur_col;
            end
        end else if (de_q) begin  // end of an active line
            sub_x <= '0;
            if (sub_y == SUB_LAST) begin
                sub_y    <= '0;
                row_base <= row_base + ROW_STEP;
                col_addr <= row_base + ROW_STEP;
            end else begin
                sub_y    <= sub_y + 1'b1;
                col_addr <= row_base;  // repeat same fb row
            end
        end
    end

    always_comb rgb = de_q ? line_pkg::PALETTE[cidx_q] : '0;  // black in blanking

endmodule

`default_nettype wire

// ==== source/top_line.sv ====
// ======================================================================
// top line
// line drawing video subsystem with registered sync and colour outputs
// ======================================================================

`default_nettype none
`timescale 1ns/10ps

module top_line #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240,
    parameter int SCALE     = 2
) (
    input  wire logic                clk_pix,
    input  wire logic                rst,
    input  wire logic                cmd_valid,
    input  wire line_pkg::line_cmd_t cmd,
    output logic                     cmd_busy,
    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output logic                     vga_de,
    output line_pkg::rgb_t           vga_rgb
);

    line_pkg::coord_t sx, sy;
    line_pkg::fb_wr_t fb_wr;
    line_pkg::rgb_t   fb_rgb;
    logic hsync, vsync, de, frame;
    logic fb_we;
    logic hsync_p1, vsync_p1, de_p1;  // match the framebuffer read stage

    display_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame,
        .line ()
    );

    draw_sequencer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_seq (
        .clk_pix, .rst, .cmd_valid, .frame, .cmd, .cmd_busy, .fb_we, .fb_wr
    );

    framebuffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .SCALE     (SCALE)
    ) u_fb (
        .clk_pix, .fb_we, .de, .fb_wr, .sx, .sy,
        .rgb (fb_rgb)
    );

    // two stages for sync and de, colour already one behind
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_p1  <= 1'b1;
            vsync_p1  <= 1'b1;
            de_p1     <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
        end else begin
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            de_p1     <= de;
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_de    <= de_p1;
        end
    end

    always_ff @(posedge clk_pix) vga_rgb <= fb_rgb;  // black outside de

endmodule

`default_nettype wire

// ==== tb/tb_top_line.sv ====
// ======================================================================
// line subsystem testbench
// drives commands from the stim file and checks whole frames at the video outputs
// ======================================================================

`default_nettype none
`timescale 1ns/10ps

module tb_top_line;

    localparam int H_ACTIVE  = 32;
    localparam int V_ACTIVE  = 24;
    localparam int H_TOTAL   = 40;  // 32 + 2 + 4 + 2
    localparam int V_TOTAL   = 28;  // 24 + 1 + 2 + 1
    localparam int FB_W      = 16;
    localparam int FB_H      = 12;
    localparam int SCALE     = 2;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int CLK_NS    = 20;

    // one stim record whose pixels sit in px_q/py_q from index first
    typedef struct packed {
        logic [127:0] name;
        int op, x0, y0, x1, y1, cidx, dup, n, first;
    } rec_t;

    logic clk_pix, rst, cmd_valid;
    line_pkg::line_cmd_t cmd;
    logic cmd_busy, vga_hsync, vga_vsync, vga_de;
    line_pkg::rgb_t vga_rgb;

    rec_t recs [$];
    int px_q [$];
    int py_q [$];
    int ref_img [FB_W*FB_H];  // expected colour index per fb cell
    int errs, n_run, n_pass, n_fail;
    logic [31:0] lfsr;
    bit loaded;

    top_line #(
        .H_ACTIVE (32), .H_FRONT (2), .H_SYNC (4), .H_BACK (2),
        .V_ACTIVE (24), .V_FRONT (1), .V_SYNC (2), .V_BACK (1),
        .FB_WIDTH (FB_W), .FB_HEIGHT (FB_H), .SCALE (SCALE)
    ) uut (
        .clk_pix, .rst, .cmd_valid, .cmd, .cmd_busy,
        .vga_hsync, .vga_vsync, .vga_de, .vga_rgb
    );

    initial begin : clock
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_stim(output bit ok);
        int fd, got, op, x0, y0, x1, y1, ci, dup, n, x, y;
        logic [127:0] nm;
        logic [8*160-1:0] text;
        ok = 1'b0;
        fd = $fopen("tb/line_stim.txt", "r");
        if (fd != 0) begin
            got = $fgets(text, fd);  // column notes
            got = $fgets(text, fd);
            got = $fscanf(fd, "%s %d %d %d %d %d %d %d %d",
                          nm, op, x0, y0, x1, y1, ci, dup, n);
            while (got == 9) begin
                recs.push_back('{nm, op, x0, y0, x1, y1, ci, dup, n, px_q.size()});
                for (int k = 0; k < n; k++) begin
                    got = $fscanf(fd, "%d %d", x, y);
                    px_q.push_back(x);
                    py_q.push_back(y);
                end
                got = $fscanf(fd, "%s %d %d %d %d %d %d %d %d",
                              nm, op, x0, y0, x1, y1, ci, dup, n);
            end
            $fclose(fd);
            ok = (recs.size() > 0);
        end
    endtask

    // one strobe set up 2 ns after the edge
    task automatic send_cmd(input int op, x0, y0, x1, y1, cidx);
        @(posedge clk_pix);
        #2;
        cmd_valid = 1'b1;
        cmd.op    = line_pkg::cmd_op_t'(op[0]);
        cmd.x0    = line_pkg::coord_t'(x0);
        cmd.y0    = line_pkg::coord_t'(y0);
        cmd.x1    = line_pkg::coord_t'(x1);
        cmd.y1    = line_pkg::coord_t'(y1);
        cmd.cidx  = line_pkg::cidx_t'(cidx);
        @(posedge clk_pix);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic check_after_reset();
        @(negedge clk_pix);
        while (vga_de !== 1'b1) begin  // until first active pixel
            if (vga_de !== 1'b0 || vga_hsync !== 1'b1 || vga_vsync !== 1'b1
                    || cmd_busy !== 1'b0) begin
                errs++;
                $display("FAILED after_reset: expected de/hs/vs/busy 0110 actual %b%b%b%b",
                         vga_de, vga_hsync, vga_vsync, cmd_busy);
            end
            @(negedge clk_pix);
        end
    endtask

    // one frame from vsync fall to vsync fall with lines split at hsync falls
    task automatic check_sync();
        int cyc, de_cyc, lines, de_lines;
        logic hs_q, vs_q;
        bit fin;
        cyc = 0;
        de_cyc = 0;
        lines = 0;
        de_lines = 0;
        fin = 1'b0;
        @(negedge clk_pix);
        while (!vga_vsync) @(negedge clk_pix);
        while (vga_vsync) @(negedge clk_pix);
        hs_q = vga_hsync;
        vs_q = vga_vsync;
        while (!fin) begin
            @(negedge clk_pix);
            if (hs_q && !vga_hsync) begin
                if (lines > 0 && (cyc != H_TOTAL || (de_cyc != 0 && de_cyc != H_ACTIVE))) begin
                    errs++;
                    // cycles and de cycles per line
                    $display("FAILED sync_geometry line %0d: expected %0d/%0d actual %0d/%0d",
                             lines, H_TOTAL, H_ACTIVE, cyc, de_cyc);
                end
                if (de_cyc == H_ACTIVE) de_lines++;
                lines++;
                cyc = 0;
                de_cyc = 0;
            end
            cyc++;
            if (vga_de) de_cyc++;
            fin = vs_q && !vga_vsync;  // next frame's vsync
            hs_q = vga_hsync;
            vs_q = vga_vsync;
        end
        if (lines != V_TOTAL || de_lines != V_ACTIVE) begin
            errs++;
            // all lines and active lines per frame
            $display("FAILED sync_geometry frame: expected %0d/%0d actual %0d/%0d",
                     V_TOTAL, V_ACTIVE, lines, de_lines);
        end
    endtask

    // next whole frame against the reference with 2x2 pixels per fb cell
    task automatic check_frame(input logic [127:0] name);
        int row, col, shown;
        line_pkg::rgb_t exp_rgb;
        row = 0;
        col = 0;
        shown = 0;
        @(negedge clk_pix);
        while (!vga_vsync) @(negedge clk_pix);
        while (vga_vsync) @(negedge clk_pix);
        while (row < V_ACTIVE) begin
            @(negedge clk_pix);
            if (vga_de) begin
                exp_rgb = line_pkg::PALETTE[ref_img[(row / SCALE) * FB_W + col / SCALE]];
                if (vga_rgb !== exp_rgb) begin
                    errs++;
                    if (shown < 4) $display("FAILED %0s pixel (%0d,%0d): expected %h actual %h",
                                            name, col, row, exp_rgb, vga_rgb);
                    shown++;
                end
                col++;
                if (col == H_ACTIVE) begin  // own position from de runs
                    col = 0;
                    row++;
                end
            end else if (vga_rgb !== '0) begin
                errs++;
                if (shown < 4) $display("FAILED %0s blank colour: expected 000 actual %h",
                                        name, vga_rgb);
                shown++;
            end
        end
    endtask

    task automatic run_record(input rec_t r);
        int ci;
        ci = r.cidx;
        if (ci > 15) rand_bits(4, ci);  // random clear colour
        send_cmd(r.op, r.x0, r.y0, r.x1, r.y1, ci);
        @(negedge clk_pix);
        if (cmd_busy !== 1'b1) begin
            errs++;
            $display("FAILED %0s cmd_busy: expected 1 actual %b", r.name, cmd_busy);
        end
        if (r.dup != 0) send_cmd(0, 0, 0, 0, 0, 15);  // white clear that lands while busy
        while (cmd_busy !== 1'b0) @(negedge clk_pix);
        if (r.op == 0) begin
            foreach (ref_img[k]) ref_img[k] = ci;
        end
        for (int k = r.first; k < r.first + r.n; k++) ref_img[py_q[k] * FB_W + px_q[k]] = ci;
        check_frame(r.name);
    endtask

    task automatic log_result(input logic [127:0] name);
        n_run++;
        if (errs == 0) begin
            n_pass++;
            $display("test %0s passed", name);
        end else begin
            n_fail++;
            $display("test %0s had %0d errors", name, errs);
        end
    endtask

    initial begin : main
        bit ok;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        lfsr = 32'hd1643117;
        load_stim(ok);
        if (!ok) begin
            $display("stim file tb/line_stim.txt missing or empty");
            n_fail++;
        end else begin
            loaded = 1'b1;
            repeat (4) @(posedge clk_pix);
            #2 rst = 1'b0;
            errs = 0;
            check_after_reset();
            log_result("after_reset");
            errs = 0;
            check_sync();
            log_result("sync_geometry");
            foreach (recs[i]) begin
                errs = 0;
                run_record(recs[i]);
                log_result(recs[i].name);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", n_run, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // about three frames per test with some spare
    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = (recs.size() + 2) * 3 * FRAME_CYC * CLK_NS;
        #(limit_ns);
        $display("watchdog expired after %0d ns, tests did not finish", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/line_stim.txt ====
# columns name op x0 y0 x1 y1 cidx dup n and then n pixel pairs x y
# op 0 is clear and 1 is line  cidx 16 takes an lfsr colour  dup 1 sends a strobe while busy
clear_fixed   0  0  0  0  0  3 0 0
clear_random  0  0  0  0  0 16 0 0
clear_bg      0  0  0  0  0  1 0 0
horizontal    1  1  1 10  1  7 0 10
 1 1  2 1  3 1  4 1  5 1  6 1  7 1  8 1  9 1  10 1
vertical      1 14  2 14  9 10 0 8
 14 2  14 3  14 4  14 5  14 6  14 7  14 8  14 9
steep         1  2  3  5 10 13 0 8
 2 3  2 4  3 5  3 6  4 7  4 8  5 9  5 10
shallow       1  6  5 13  8 12 0 8
 6 5  7 5  8 6  9 6  10 7  11 7  12 8  13 8
reversed      1  3 11 12  9  4 0 10
 12 9  11 9  10 9  9 10  8 10  7 10  6 10  5 11  4 11  3 11
single_point  1  0  0  0  0 15 0 1
 0 0
busy_strobe   1  0 11  2 11  8 1 3
 0 11  1 11  2 11
clip_right    1 13  4 19  4  9 0 3
 13 4  14 4  15 4
clip_negative 1 -3 -2  2  3 11 0 3
 0 1  1 2  2 3

// ==== Makefile ====
# Verilator lint and simulation for the line drawing subsystem

VERILATOR ?= verilator
TOP       ?= tb_top_line
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# status comes from the search for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
source/line_pkg.sv
source/display_timing.sv
source/draw_line.sv
source/draw_sequencer.sv
source/framebuffer.sv
source/top_line.sv
tb/tb_top_line.sv
